/* design/rv_pkg.sv */
// shared types and constants for the five-stage rv32i core
// every stage refers to these through rv_pkg:: scoped names
package rv_pkg;

    localparam int xlen       = 32;   // data and address width
    localparam int reg_addr_w = 5;    // register index width

    // ----------------------------------------------------------
    // encodings
    // ----------------------------------------------------------
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,   // add sub and or
        op_imm    = 7'b0010011,   // addi
        op_load   = 7'b0000011,   // lw
        op_store  = 7'b0100011,   // sw
        op_branch = 7'b1100011    // beq bne blt bge
    } opcode_e;

    typedef enum logic [1:0] {
        alu_add,    // zero value, so a bubble decodes as add
        alu_sub,
        alu_and,
        alu_or
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,    // zero value, not a branch
        br_eq,
        br_ne,
        br_lt,      // signed
        br_ge       // signed
    } branch_e;

    // ----------------------------------------------------------
    // pipeline registers, all-zero value is a bubble
    // ----------------------------------------------------------
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        alu_op_e               alu_op;
        branch_e               branch;
        logic                  alu_src;     // second alu input is imm
        logic                  use_rs2;     // rs2 is a real source
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_result;  // also the memory address
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] rd;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0]       value;       // already muxed load or alu
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
    } mem_wb_t;

endpackage

/* design/rv_redirect_if.sv */
// control path between front end and back end
// back end redirects fetch on a taken branch, decode requests a load-use stall
`timescale 1ns/1ns

interface rv_redirect_if;

    logic                    branch_taken;   // from ex, wins over stall
    logic [rv_pkg::xlen-1:0] branch_target;  // pc + imm of the branch
    logic                    load_stall;     // from id, hold pc and if/id

    // fetch and decode both sit on the front side
    modport front (
        input  branch_taken,
        input  branch_target,
        output load_stall
    );

    modport back (
        output branch_taken,
        output branch_target
    );

endinterface

/* design/rv_result_if.sv */
// result buses from the mem and wb stages
// used by execute for forwarding and by the register file for writeback
`timescale 1ns/1ns

interface rv_result_if;

    logic [rv_pkg::reg_addr_w-1:0] mem_rd;
    logic                          mem_reg_write;
    logic [rv_pkg::xlen-1:0]       mem_value;      // ex/mem alu result
    logic [rv_pkg::reg_addr_w-1:0] wb_rd;
    logic                          wb_reg_write;
    logic [rv_pkg::xlen-1:0]       wb_value;       // final writeback data

    modport memwb (
        output mem_rd, mem_reg_write, mem_value,
        output wb_rd, wb_reg_write, wb_value
    );

    modport exec (
        input mem_rd, mem_reg_write, mem_value,
        input wb_rd, wb_reg_write, wb_value
    );

    modport regfile (input wb_rd, wb_reg_write, wb_value);

endinterface

/* design/rv_fetch.sv */
// fetch stage: pc register, instruction memory address and if/id register
// a taken branch reloads the pc and flushes if/id, a load-use stall holds both
`timescale 1ns/1ns

module rv_fetch (
    input  logic                    clk,
    input  logic                    reset_b,
    rv_redirect_if.front            redirect,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  logic [31:0]             imem_data,
    output rv_pkg::if_id_t          if_id
);

    logic [rv_pkg::xlen-1:0] pc;

    assign imem_addr = pc;    // byte address, always word aligned

    // ----------------------------------------------------------
    // program counter
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            pc <= '0;
        end else if (redirect.branch_taken) begin
            pc <= redirect.branch_target;
        end else if (!redirect.load_stall) begin
            pc <= pc + 32'd4;
        end
        // else hold for the stall
    end

    // if/id, flush wins over hold
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            if_id <= '0;
        end else if (redirect.branch_taken) begin
            if_id <= '0;                        // shadow slot becomes bubble
        end else if (!redirect.load_stall) begin
            if_id.pc   <= pc;
            if_id.inst <= imem_data;
        end
    end

endmodule

/* design/rv_decode.sv */
// decode stage: control decoder, immediate generator, register file
// also detects load-use hazards and holds the id/ex register
`timescale 1ns/1ns

module rv_decode (
    input  logic           clk,
    input  logic           reset_b,
    input  rv_pkg::if_id_t if_id,
    rv_redirect_if.front   redirect,
    rv_result_if.regfile   result,
    output rv_pkg::id_ex_t id_ex
);

    logic [rv_pkg::xlen-1:0]       regs [32];   // x0 entry never written
    logic [rv_pkg::reg_addr_w-1:0] rs1, rs2, rd;
    logic [2:0]                    funct3;
    logic                          funct7_b5;
    logic [rv_pkg::xlen-1:0]       imm_i, imm_s, imm_b;
    rv_pkg::id_ex_t                id_ex_d;

    // instruction fields
    assign rs1       = if_id.inst[19:15];
    assign rs2       = if_id.inst[24:20];
    assign rd        = if_id.inst[11:7];
    assign funct3    = if_id.inst[14:12];
    assign funct7_b5 = if_id.inst[30];     // sub vs add

    // ----------------------------------------------------------
    // immediates, sign extended
    // ----------------------------------------------------------
    assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
    assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
    assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
                    if_id.inst[30:25], if_id.inst[11:8], 1'b0};   // already << 1

    // ----------------------------------------------------------
    // main decoder
    // ----------------------------------------------------------
    always_comb begin
        id_ex_d     = '0;          // unknown opcode acts as a bubble
        id_ex_d.pc  = if_id.pc;
        id_ex_d.rs1 = rs1;
        id_ex_d.rs2 = rs2;
        id_ex_d.rd  = rd;
        // regfile read with write-first bypass from wb
        id_ex_d.rs1_val = (rs1 == '0) ? '0 :
            (result.wb_reg_write && result.wb_rd == rs1) ? result.wb_value : regs[rs1];
        id_ex_d.rs2_val = (rs2 == '0) ? '0 :
            (result.wb_reg_write && result.wb_rd == rs2) ? result.wb_value : regs[rs2];
        case (rv_pkg::opcode_e'(if_id.inst[6:0]))
            rv_pkg::op_r: begin
                id_ex_d.use_rs2   = 1'b1;
                id_ex_d.reg_write = 1'b1;
                case (funct3)
                    3'b111:  id_ex_d.alu_op = rv_pkg::alu_and;
                    3'b110:  id_ex_d.alu_op = rv_pkg::alu_or;
                    default: id_ex_d.alu_op = funct7_b5 ? rv_pkg::alu_sub : rv_pkg::alu_add;
                endcase
            end
            rv_pkg::op_imm: begin          // addi only
                id_ex_d.imm       = imm_i;
                id_ex_d.alu_src   = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            rv_pkg::op_load: begin
                id_ex_d.imm       = imm_i;
                id_ex_d.alu_src   = 1'b1;
                id_ex_d.mem_read  = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            rv_pkg::op_store: begin
                id_ex_d.imm       = imm_s;
                id_ex_d.alu_src   = 1'b1;
                id_ex_d.use_rs2   = 1'b1;  // store data
                id_ex_d.mem_write = 1'b1;
            end
            rv_pkg::op_branch: begin
                id_ex_d.imm     = imm_b;
                id_ex_d.use_rs2 = 1'b1;
                case (funct3)
                    3'b000:  id_ex_d.branch = rv_pkg::br_eq;
                    3'b001:  id_ex_d.branch = rv_pkg::br_ne;
                    3'b100:  id_ex_d.branch = rv_pkg::br_lt;
                    3'b101:  id_ex_d.branch = rv_pkg::br_ge;
                    default: id_ex_d.branch = rv_pkg::br_none;   // unsigned forms
                endcase
            end
            default: ;
        endcase
    end

    // load in ex feeding this instruction, x0 never stalls
    assign redirect.load_stall = id_ex.mem_read && (id_ex.rd != '0) &&
        ((id_ex.rd == rs1) || (id_ex_d.use_rs2 && (id_ex.rd == rs2)));

    // register file write at the end of wb
    always_ff @(posedge clk) begin
        if (result.wb_reg_write && result.wb_rd != '0) begin
            regs[result.wb_rd] <= result.wb_value;
        end
    end

    // id/ex, bubble on stall or flush
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            id_ex <= '0;
        end else if (redirect.branch_taken || redirect.load_stall) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

/* design/rv_execute.sv */
// execute stage: forwarding, alu, branch resolution and the ex/mem register
// a taken branch here redirects fetch and flushes the two younger stages
`timescale 1ns/1ns

module rv_execute (
    input  logic            clk,
    input  logic            reset_b,
    input  rv_pkg::id_ex_t  id_ex,
    rv_redirect_if.back     redirect,
    rv_result_if.exec       result,
    output rv_pkg::ex_mem_t ex_mem
);

    logic                    fwd_a_mem, fwd_a_wb;
    logic                    fwd_b_mem, fwd_b_wb;
    logic [rv_pkg::xlen-1:0] op_a, op_b;      // forwarded rs1 / rs2
    logic [rv_pkg::xlen-1:0] alu_in2;
    logic [rv_pkg::xlen-1:0] alu_result;
    logic                    eq, lt;

    // ----------------------------------------------------------
    // forwarding unit, ex/mem beats mem/wb, rd zero never forwards
    // ----------------------------------------------------------
    assign fwd_a_mem = result.mem_reg_write && (result.mem_rd != '0) &&
                       (result.mem_rd == id_ex.rs1);
    assign fwd_a_wb  = result.wb_reg_write && (result.wb_rd != '0) &&
                       (result.wb_rd == id_ex.rs1);
    assign fwd_b_mem = id_ex.use_rs2 && result.mem_reg_write &&
                       (result.mem_rd != '0) && (result.mem_rd == id_ex.rs2);
    assign fwd_b_wb  = id_ex.use_rs2 && result.wb_reg_write &&
                       (result.wb_rd != '0) && (result.wb_rd == id_ex.rs2);

    assign op_a = fwd_a_mem ? result.mem_value :
                  fwd_a_wb  ? result.wb_value  : id_ex.rs1_val;
    assign op_b = fwd_b_mem ? result.mem_value :
                  fwd_b_wb  ? result.wb_value  : id_ex.rs2_val;

    assign alu_in2 = id_ex.alu_src ? id_ex.imm : op_b;   // addr offset or addi imm

    // alu
    always_comb begin
        case (id_ex.alu_op)
            rv_pkg::alu_sub: alu_result = op_a - alu_in2;
            rv_pkg::alu_and: alu_result = op_a & alu_in2;
            rv_pkg::alu_or:  alu_result = op_a | alu_in2;
            default:         alu_result = op_a + alu_in2;
        endcase
    end

    // ----------------------------------------------------------
    // branch unit, signed compare on forwarded operands
    // ----------------------------------------------------------
    assign eq = (op_a == op_b);
    assign lt = ($signed(op_a) < $signed(op_b));

    always_comb begin
        case (id_ex.branch)
            rv_pkg::br_eq: redirect.branch_taken = eq;
            rv_pkg::br_ne: redirect.branch_taken = !eq;
            rv_pkg::br_lt: redirect.branch_taken = lt;
            rv_pkg::br_ge: redirect.branch_taken = !lt;
            default:       redirect.branch_taken = 1'b0;
        endcase
    end

    assign redirect.branch_target = id_ex.pc + id_ex.imm;   // b imm carries the << 1

    // ex/mem, a branch leaves no write behind
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            ex_mem <= '0;
        end else begin
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= op_b;       // forwarded store data
            ex_mem.rd         <= id_ex.rd;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.reg_write  <= id_ex.reg_write;
        end
    end

endmodule

/* design/rv_memwb.sv */
// memory and writeback stage: drives the data memory port from ex/mem
// selects the load data or alu result into mem/wb and publishes both buses
`timescale 1ns/1ns

module rv_memwb (
    input  logic                    clk,
    input  logic                    reset_b,
    input  rv_pkg::ex_mem_t         ex_mem,
    rv_result_if.memwb              result,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    output logic                    dmem_we,
    output logic                    dmem_re,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata
);

    rv_pkg::mem_wb_t mem_wb;

    // data memory, strobes low in bubbles
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.mem_write;
    assign dmem_re    = ex_mem.mem_read;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            mem_wb <= '0;
        end else begin
            mem_wb.value     <= ex_mem.mem_read ? dmem_rdata : ex_mem.alu_result;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.reg_write <= ex_mem.reg_write;
        end
    end

    // result buses for forwarding and the register file
    assign result.mem_rd        = ex_mem.rd;
    assign result.mem_reg_write = ex_mem.reg_write;
    assign result.mem_value     = ex_mem.alu_result;
    assign result.wb_rd         = mem_wb.rd;
    assign result.wb_reg_write  = mem_wb.reg_write;
    assign result.wb_value      = mem_wb.value;

endmodule

/* design/rv_core.sv */
// top level of the five-stage rv32i core
// instruction and data memories sit outside, on the imem_* and dmem_* ports
`timescale 1ns/1ns

module rv_core (
    input  logic                    clk,
    input  logic                    reset_b,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  logic [31:0]             imem_data,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    output logic                    dmem_we,
    output logic                    dmem_re,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata
);

    rv_pkg::if_id_t  if_id;
    rv_pkg::id_ex_t  id_ex;
    rv_pkg::ex_mem_t ex_mem;

    rv_redirect_if redirect_i ();
    rv_result_if   result_i ();

    // ----------------------------------------------------------
    // front end
    // ----------------------------------------------------------
    rv_fetch fetch_i (
        .clk       (clk),
        .reset_b   (reset_b),
        .redirect  (redirect_i.front),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .if_id     (if_id)
    );

    rv_decode decode_i (
        .clk      (clk),
        .reset_b  (reset_b),
        .if_id    (if_id),
        .redirect (redirect_i.front),
        .result   (result_i.regfile),
        .id_ex    (id_ex)
    );

    // ----------------------------------------------------------
    // back end
    // ----------------------------------------------------------
    rv_execute execute_i (
        .clk      (clk),
        .reset_b  (reset_b),
        .id_ex    (id_ex),
        .redirect (redirect_i.back),
        .result   (result_i.exec),
        .ex_mem   (ex_mem)
    );

    rv_memwb memwb_i (
        .clk        (clk),
        .reset_b    (reset_b),
        .ex_mem     (ex_mem),
        .result     (result_i.memwb),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

endmodule

/* tests/rv_core_sva.sv */
// protocol checks on the core's memory ports, bound onto rv_core
`timescale 1ns/1ns

module rv_core_sva (
    input logic        clk,
    input logic        reset_b,
    input logic [31:0] imem_addr,
    input logic        dmem_we,
    input logic        dmem_re
);

    int fail_count = 0;

    // one data access per cycle at most
    we_re_excl: assert property (@(posedge clk) disable iff (!reset_b)
        !(dmem_we && dmem_re))
        else begin
            $error("dmem_we and dmem_re high in the same cycle");
            fail_count++;
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (!reset_b)
        imem_addr[1:0] == 2'b00)
        else begin
            $error("imem_addr not word aligned");
            fail_count++;
        end

    // ----------------------------------------------------------
    // reset release
    // ----------------------------------------------------------
    first_fetch: assert property (@(posedge clk) $rose(reset_b) |-> imem_addr == '0)
        else begin
            $error("first fetch after reset is not at address 0");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk) $rose(reset_b) |=> !dmem_we)
        else begin
            $error("dmem_we high right after reset release");
            fail_count++;
        end

endmodule

bind rv_core rv_core_sva sva_i (.*);

/* tests/rv_core_tb.sv */
// testbench for the five-stage rv32i core
// models both memories, assembles a small program and checks every store and load
// against an ISA-level model of the same program, in program order
`timescale 1ns/1ns

module rv_core_tb;

    typedef struct {
        logic [31:0] addr;
        logic [31:0] data;
        int          test;
    } store_t;

    logic        clk;
    logic        reset_b;
    logic [31:0] imem_addr, imem_data;
    logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
    logic        dmem_we, dmem_re;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    logic [31:0] mm [64];      // model memory
    logic [31:0] xr [32];      // model register file
    store_t      exp_q [$];    // expected stores in program order
    logic [31:0] load_q [$];   // expected load addresses
    int          prog_len, shadow, pending;
    int          test_err [4];
    int          n_ok, n_bad, port_err;
    bit          built;
    integer      seed;
    string       test_name [4] = '{"alu_forward", "load_use", "branches", "x0_reg"};

    rv_core dut_i (.*);

    // past the program the fetch sees addi x0 nops tagged by the folded address
    assign imem_data  = (imem_addr[31:2] < prog_len) ? imem[imem_addr[9:2]]
                      : {imem_addr[13:2] ^ imem_addr[25:14] ^ {6'd0, imem_addr[31:26]},
                         13'd0, 7'b0010011};
    assign dmem_rdata = dmem[dmem_addr[7:2]];   // same-cycle read

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------------------------
    // instruction encoders
    // ----------------------------------------------------------
    function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_format(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd, rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_format(input logic [4:0] rs2, rs1,
                                             input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_format(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                             input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // appends one word and returns 0 inside a taken branch's shadow
    function automatic bit emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
        if (shadow > 0) begin
            shadow--;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // ----------------------------------------------------------
    // program builder with the ISA model alongside
    // ----------------------------------------------------------
    task automatic write_reg(input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0)
            xr[rd] = value;    // x0 stays zero
    endtask

    task automatic reg_op(input string op, input logic [4:0] rd, rs1, rs2);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        case (op)
            "sub":   r = xr[rs1] - xr[rs2];
            "and":   r = xr[rs1] & xr[rs2];
            "or":    r = xr[rs1] | xr[rs2];
            default: r = xr[rs1] + xr[rs2];
        endcase
        f3 = (op == "and") ? 3'b111 : (op == "or") ? 3'b110 : 3'b000;
        f7 = (op == "sub") ? 7'h20 : 7'h00;
        if (emit(r_format(f7, f3, rd, rs1, rs2)))
            write_reg(rd, r);
    endtask

    task automatic add_imm(input logic [4:0] rd, rs1, input logic [11:0] imm);
        if (emit(i_format(7'b0010011, 3'b000, rd, rs1, imm)))
            write_reg(rd, xr[rs1] + {{20{imm[11]}}, imm});
    endtask

    task automatic load_word(input logic [4:0] rd, rs1, input logic [11:0] off);
        logic [31:0] addr;
        addr = xr[rs1] + {{20{off[11]}}, off};
        if (emit(i_format(7'b0000011, 3'b010, rd, rs1, off))) begin
            write_reg(rd, mm[addr[7:2]]);
            load_q.push_back(addr);
        end
    endtask

    task automatic store_word(input logic [4:0] rs2, rs1, input logic [11:0] off,
                              input int test);
        store_t e;
        e.addr = xr[rs1] + {{20{off[11]}}, off};
        e.data = xr[rs2];
        e.test = test;
        if (emit(s_format(rs2, rs1, off))) begin
            mm[e.addr[7:2]] = e.data;
            exp_q.push_back(e);
            pending++;
        end
    endtask

    // fixed offset of 12 so a taken branch skips two slots
    task automatic cond_branch(input logic [2:0] f3, input logic [4:0] rs1, rs2);
        logic taken;
        case (f3)
            3'b000:  taken = (xr[rs1] == xr[rs2]);
            3'b001:  taken = (xr[rs1] != xr[rs2]);
            3'b100:  taken = ($signed(xr[rs1]) < $signed(xr[rs2]));
            default: taken = ($signed(xr[rs1]) >= $signed(xr[rs2]));
        endcase
        if (emit(b_format(f3, rs1, rs2, 13'd12)) && taken)
            shadow = 2;
    endtask

    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                               input int idx);
        cond_branch(f3, rs1, rs2);
        store_word(21, 0, 40 + 8 * idx, 2);   // fall-through marker
        add_imm(21, 21, 1);                   // bumps the marker if not flushed
        store_word(21, 0, 44 + 8 * idx, 2);   // join point reached on both paths
    endtask

    task automatic build_program();
        // alu chain at distances 1 and 2
        load_word(1, 0, 128);
        load_word(2, 0, 132);
        reg_op("add", 3, 1, 2);
        reg_op("sub", 4, 3, 1);
        reg_op("and", 5, 4, 3);
        reg_op("or", 6, 5, 2);
        add_imm(7, 6, -123);
        reg_op("add", 8, 7, 5);
        for (int i = 3; i <= 8; i++) begin
            store_word(i, 0, 4 * (i - 3), 0);
        end
        reg_op("sub", 9, 8, 2);
        store_word(9, 0, 24, 0);          // store data from ex/mem
        // load-use
        load_word(17, 0, 136);
        reg_op("add", 18, 17, 3);
        store_word(18, 0, 28, 1);
        store_word(17, 0, 32, 1);
        // branch operands
        load_word(10, 0, 140);
        load_word(11, 0, 144);
        add_imm(12, 10, 0);               // equal copy for beq
        add_imm(14, 0, -2048);
        reg_op("or", 13, 10, 14);         // forced negative
        add_imm(16, 0, 2047);
        load_word(21, 0, 148);            // marker seed
        branch_case(3'b000, 10, 12, 0);
        branch_case(3'b000, 10, 11, 1);
        branch_case(3'b001, 10, 11, 2);
        branch_case(3'b001, 10, 12, 3);
        branch_case(3'b100, 10, 11, 4);   // one of each order is taken
        branch_case(3'b100, 11, 10, 5);
        branch_case(3'b101, 10, 11, 6);
        branch_case(3'b101, 11, 10, 7);
        branch_case(3'b100, 13, 16, 8);   // taken only as signed
        branch_case(3'b101, 13, 16, 9);
        // x0 as destination and as forwarding source
        add_imm(0, 0, 55);
        store_word(0, 0, 120, 3);
        add_imm(0, 3, 77);
        add_imm(22, 1, 0);
        store_word(0, 0, 124, 3);         // rd zero sits in mem/wb here
    endtask

    // ----------------------------------------------------------
    // store and load checks at negedge where the ports are settled
    // ----------------------------------------------------------
    task automatic finish_test(input int t);
        if (test_err[t] == 0)
            n_ok++;
        else
            n_bad++;
        $display("test %0d %s done with %0d errors", t, test_name[t], test_err[t]);
    endtask

    task automatic check_store();
        store_t e;
        assert (exp_q.size() != 0) else begin
            $display("store to %h at %0t arrived when none was expected", dmem_addr, $time);
            port_err++;
        end
        dmem[dmem_addr[7:2]] = dmem_wdata;
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            pending--;
            assert (dmem_addr == e.addr) else begin
                $display("FAIL %0t dmem_addr expected %h actual %h", $time, e.addr, dmem_addr);
                test_err[e.test]++;
            end
            assert (dmem_wdata == e.data) else begin
                $display("FAIL %0t dmem_wdata expected %h actual %h", $time, e.data, dmem_wdata);
                test_err[e.test]++;
            end
            if (exp_q.size() == 0 || exp_q[0].test != e.test)
                finish_test(e.test);
        end
    endtask

    task automatic check_load();
        logic [31:0] a;
        assert (load_q.size() != 0) else begin
            $display("load from %h at %0t arrived when none was expected", dmem_addr, $time);
            port_err++;
        end
        if (load_q.size() != 0) begin
            a = load_q.pop_front();
            assert (dmem_addr == a) else begin
                $display("FAIL %0t dmem_addr expected %h actual %h", $time, a, dmem_addr);
                port_err++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (reset_b && dmem_we)
            check_store();
        if (reset_b && dmem_re)
            check_load();
    end

    initial begin
        seed    = 32'hce93;
        reset_b = 1'b0;
        foreach (xr[i]) xr[i] = '0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $random(seed);
            mm[i]   = dmem[i];
        end
        build_program();
        built = 1'b1;
        repeat (4) @(posedge clk);
        #2 reset_b = 1'b1;
        wait (pending == 0);
        repeat (4) @(posedge clk);       // room for a stray store
        assert (load_q.size() == 0) else begin
            $display("%0d expected loads never reached the data port", load_q.size());
            port_err++;
        end
        $display("%0d tests ok, %0d with errors, %0d memory port errors, %0d sva failures",
                 n_ok, n_bad, port_err, dut_i.sva_i.fail_count);
        if (n_ok == 4 && n_bad == 0 && port_err == 0 && dut_i.sva_i.fail_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // watchdog scaled by program length
    initial begin
        wait (built);
        repeat ((prog_len + 40) * 4) @(posedge clk);
        $display("timeout, %0d expected stores never arrived", pending);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* src.f */
design/rv_pkg.sv
design/rv_redirect_if.sv
design/rv_result_if.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_memwb.sv
design/rv_core.sv
tests/rv_core_sva.sv
tests/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - design/rv_pkg.sv
  - design/rv_redirect_if.sv
  - design/rv_result_if.sv
  - design/rv_fetch.sv
  - design/rv_decode.sv
  - design/rv_execute.sv
  - design/rv_memwb.sv
  - design/rv_core.sv
  - target: test
    files:
      - tests/rv_core_sva.sv
      - tests/rv_core_tb.sv
